// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := lsu_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/lsu_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types and widths of the load/store unit, referenced
// by scoped name from every design file
////////////////////////////////////////////////////////////

package lsu_pkg;

  // Data and address width
  localparam int LSU_XLEN = 32;
  // Bytes per bus word
  localparam int LSU_NBYTES = 4;

  //////////////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////////////

  // Memory operation opcodes
  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } lsu_opcode_e;

  // Request generator state, second phase only for split accesses
  typedef enum logic {
    PH_FIRST,
    PH_SECOND
  } lsu_phase_e;

  //////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////

  // Operation from the issue port
  typedef struct packed {
    lsu_opcode_e           opcode;
    logic [LSU_XLEN-1:0]   addr;
    logic [LSU_XLEN-1:0]   wdata;
  } lsu_op_t;

  // Data bus request, OBI-like
  typedef struct packed {
    logic [LSU_XLEN-1:0]   addr;
    logic                  we;
    logic [LSU_NBYTES-1:0] be;
    logic [LSU_XLEN-1:0]   wdata;
  } bus_req_t;

  // Control info kept per outstanding transaction
  typedef struct packed {
    lsu_opcode_e opcode;
    logic [1:0]  offset;
    logic        last;
  } lsu_ctrl_t;

  // Completed operation
  typedef struct packed {
    logic [LSU_XLEN-1:0] rdata;
    logic                is_store;
  } lsu_result_t;

endpackage

// ==== design/lsu_read_align.sv ====
////////////////////////////////////////////////////////////
// Read aligner: merges split responses, extends loads and
// registers one in-order result per operation
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_read_align
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          rsp_valid_i,
  input  logic [lsu_pkg::LSU_XLEN-1:0]  rsp_rdata_i,
  input  lsu_pkg::lsu_ctrl_t            head_ctrl_i,
  output logic                          pop_o,
  output logic                          result_valid_o,
  output lsu_pkg::lsu_result_t          result_o
);

  logic [lsu_pkg::LSU_XLEN-1:0]    first_q;
  logic                            split_pend_q;
  logic                            result_valid_q;
  lsu_pkg::lsu_result_t            result_q;
  logic [lsu_pkg::LSU_XLEN-1:0]    lo_word;
  logic [2*lsu_pkg::LSU_XLEN-1:0]  window;
  logic [lsu_pkg::LSU_XLEN-1:0]    merged;
  logic [lsu_pkg::LSU_XLEN-1:0]    rdata_ext;
  logic                            is_store;

  // Every response retires one queue entry
  assign pop_o = rsp_valid_i;

  //////////////////////////////////////////////////////////
  // Byte alignment
  //////////////////////////////////////////////////////////

  // Low word is the stored first half when a split is pending
  assign lo_word = split_pend_q ? first_q : rsp_rdata_i;
  assign window  = {rsp_rdata_i, lo_word} >> {head_ctrl_i.offset, 3'b000};
  assign merged  = window[lsu_pkg::LSU_XLEN-1:0];

  assign is_store = head_ctrl_i.opcode inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};

  // Sign or zero extension by opcode
  always_comb
  begin
    case (head_ctrl_i.opcode)
      lsu_pkg::LB:  rdata_ext = {{24{merged[7]}}, merged[7:0]};
      lsu_pkg::LBU: rdata_ext = {24'h00_0000, merged[7:0]};
      lsu_pkg::LH:  rdata_ext = {{16{merged[15]}}, merged[15:0]};
      lsu_pkg::LHU: rdata_ext = {16'h0000, merged[15:0]};
      lsu_pkg::LW:  rdata_ext = merged;
      // Stores report zero data
      default:      rdata_ext = '0;
    endcase
  end

  //////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////

  // Raw data of a first half
  always_ff @(posedge clk)
  begin
    if (rsp_valid_i && !head_ctrl_i.last)
    begin
      first_q <= rsp_rdata_i;
    end
  end

  // Result payload, loaded on the last response
  always_ff @(posedge clk)
  begin
    if (rsp_valid_i && head_ctrl_i.last)
    begin
      result_q.rdata    <= rdata_ext;
      result_q.is_store <= is_store;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      split_pend_q   <= 1'b0;
      result_valid_q <= 1'b0;
    end
    else
    begin
      // Set by a first half, cleared by the closing half
      if (rsp_valid_i)
      begin
        split_pend_q <= !head_ctrl_i.last;
      end
      result_valid_q <= rsp_valid_i && head_ctrl_i.last;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

endmodule

// ==== design/lsu_request_gen.sv ====
////////////////////////////////////////////////////////////
// Request generator: turns one issued operation into one or
// two bus requests and pushes their control info to the queue
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_request_gen
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                op_valid_i,
  input  lsu_pkg::lsu_op_t    op_i,
  output logic                op_ready_o,
  output logic                bus_req_valid_o,
  output lsu_pkg::bus_req_t   bus_req_o,
  input  logic                bus_req_ready_i,
  input  logic                queue_full_i,
  output logic                push_o,
  output lsu_pkg::lsu_ctrl_t  push_ctrl_o
);

  lsu_pkg::lsu_phase_e                phase_q;
  logic [1:0]                         offset;
  logic [lsu_pkg::LSU_NBYTES-1:0]     size_mask;
  logic [2*lsu_pkg::LSU_NBYTES-1:0]   be_wide;
  logic [2*lsu_pkg::LSU_XLEN-1:0]     rot_wide;
  logic                               is_half;
  logic                               is_word;
  logic                               is_store;
  logic                               split;
  logic                               last;
  logic                               accept;

  assign offset = op_i.addr[1:0];

  // Access size from opcode
  always_comb
  begin
    size_mask = 4'b0001;
    is_half   = 1'b0;
    is_word   = 1'b0;
    case (op_i.opcode)
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH:
      begin
        size_mask = 4'b0011;
        is_half   = 1'b1;
      end
      lsu_pkg::LW, lsu_pkg::SW:
      begin
        size_mask = 4'b1111;
        is_word   = 1'b1;
      end
      default:
      begin
        size_mask = 4'b0001;
      end
    endcase
  end

  assign is_store = op_i.opcode inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};

  // Word off alignment, or halfword crossing into the next word
  assign split = (is_word && (offset != 2'b00)) || (is_half && (offset == 2'b11));
  assign last  = !(split && (phase_q == lsu_pkg::PH_FIRST));

  //////////////////////////////////////////////////////////
  // Byte enables, write data and address
  //////////////////////////////////////////////////////////

  // Low nibble is the first word, high nibble spills into the next word
  assign be_wide = {{lsu_pkg::LSU_NBYTES{1'b0}}, size_mask} << offset;

  // Rotate left by offset bytes, same data serves both halves
  assign rot_wide = {op_i.wdata, op_i.wdata} << {offset, 3'b000};

  assign bus_req_o.we    = is_store;
  assign bus_req_o.wdata = rot_wide[2*lsu_pkg::LSU_XLEN-1:lsu_pkg::LSU_XLEN];
  assign bus_req_o.be    = (phase_q == lsu_pkg::PH_SECOND) ?
                           be_wide[2*lsu_pkg::LSU_NBYTES-1:lsu_pkg::LSU_NBYTES] :
                           be_wide[lsu_pkg::LSU_NBYTES-1:0];
  // Second half goes to the next aligned word
  assign bus_req_o.addr  = (phase_q == lsu_pkg::PH_SECOND) ?
                           {op_i.addr[lsu_pkg::LSU_XLEN-1:2] + 1'b1, 2'b00} :
                           op_i.addr;

  //////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////

  // Queue depth caps the outstanding transactions
  assign bus_req_valid_o = op_valid_i && !queue_full_i;
  assign accept          = bus_req_valid_o && bus_req_ready_i;
  assign op_ready_o      = accept && last;

  assign push_o             = accept;
  assign push_ctrl_o.opcode = op_i.opcode;
  assign push_ctrl_o.offset = offset;
  assign push_ctrl_o.last   = last;

  // Phase advances only on an accepted request
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase_q <= lsu_pkg::PH_FIRST;
    end
    else if (accept)
    begin
      phase_q <= last ? lsu_pkg::PH_FIRST : lsu_pkg::PH_SECOND;
    end
  end

  // A pending request holds until the bus takes it
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_o));

endmodule

// ==== design/lsu_top.sv ====
////////////////////////////////////////////////////////////
// Load/store unit top level, issue port in, data bus out,
// in-order results back
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_top
#(
  parameter int LSU_DEPTH = 2
)
(
  input  logic                          clk,
  input  logic                          rst_n,
  // Issue port
  input  logic                          op_valid_i,
  input  lsu_pkg::lsu_op_t              op_i,
  output logic                          op_ready_o,
  // Bus request
  output logic                          bus_req_valid_o,
  output lsu_pkg::bus_req_t             bus_req_o,
  input  logic                          bus_req_ready_i,
  // Bus response
  input  logic                          bus_rsp_valid_i,
  input  logic [lsu_pkg::LSU_XLEN-1:0]  bus_rdata_i,
  // Result port
  output logic                          result_valid_o,
  output lsu_pkg::lsu_result_t          result_o
);

  logic                push;
  lsu_pkg::lsu_ctrl_t  push_ctrl;
  logic                queue_full;
  logic                pop;
  lsu_pkg::lsu_ctrl_t  head_ctrl;

  lsu_request_gen u_request_gen (
    .clk             (clk),
    .rst_n           (rst_n),
    .op_valid_i      (op_valid_i),
    .op_i            (op_i),
    .op_ready_o      (op_ready_o),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_o       (bus_req_o),
    .bus_req_ready_i (bus_req_ready_i),
    .queue_full_i    (queue_full),
    .push_o          (push),
    .push_ctrl_o     (push_ctrl)
  );

  // Depth bounds the transactions in flight
  lsu_txn_queue #(
    .DEPTH (LSU_DEPTH)
  ) u_txn_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (push),
    .push_ctrl_i  (push_ctrl),
    .queue_full_o (queue_full),
    .pop_i        (pop),
    .head_ctrl_o  (head_ctrl)
  );

  lsu_read_align u_read_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .rsp_valid_i    (bus_rsp_valid_i),
    .rsp_rdata_i    (bus_rdata_i),
    .head_ctrl_i    (head_ctrl),
    .pop_o          (pop),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

// ==== design/lsu_txn_queue.sv ====
////////////////////////////////////////////////////////////
// FIFO of control info for each bus transaction in flight
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_txn_queue
#(
  parameter int DEPTH = 2
)
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_i,
  input  lsu_pkg::lsu_ctrl_t  push_ctrl_i,
  output logic                queue_full_o,
  input  logic                pop_i,
  output lsu_pkg::lsu_ctrl_t  head_ctrl_o
);

  // Pointer and count widths, at least one bit each
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_pkg::lsu_ctrl_t  mem [DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    count_q;

  assign queue_full_o = (count_q == CNT_W'(DEPTH));
  assign head_ctrl_o  = mem[rd_ptr_q];

  // Entry storage
  always_ff @(posedge clk)
  begin
    if (push_i)
    begin
      mem[wr_ptr_q] <= push_ctrl_i;
    end
  end

  // Pointers wrap at DEPTH, count tracks occupancy
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Generator must back off when full
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !queue_full_o);

  // A bus response always has a matching request
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> (count_q != '0));

endmodule

// ==== project.f ====
design/lsu_pkg.sv
design/lsu_request_gen.sv
design/lsu_txn_queue.sv
design/lsu_read_align.sv
design/lsu_top.sv
tests/lsu_tb.sv

// ==== tests/lsu_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the load/store unit that replays the trace
// file against a stalling bus memory and checks each result
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_tb;

  localparam int DEPTH      = 2;
  localparam int TRACE_MAX  = 64;
  localparam int TRACE_COLS = 5;
  localparam int CYC_PER_OP = 40;

  logic                          clk;
  logic                          rst_n;
  logic                          op_valid_i;
  lsu_pkg::lsu_op_t              op_i;
  logic                          op_ready_o;
  logic                          bus_req_valid_o;
  lsu_pkg::bus_req_t             bus_req_o;
  logic                          bus_req_ready_i;
  logic                          bus_rsp_valid_i;
  logic [lsu_pkg::LSU_XLEN-1:0]  bus_rdata_i;
  logic                          result_valid_o;
  lsu_pkg::lsu_result_t          result_o;

  // Columns are test id, opcode, addr, store data and expected result
  logic [31:0] trace_mem [TRACE_MAX*TRACE_COLS];
  // Bus memory and its in-order response queue
  logic [7:0]  mem [64];
  logic [31:0] rsp_data_q [$];
  int          rsp_due_q [$];
  // Scoreboard with one entry per issued operation
  logic [31:0] exp_rdata_q [$];
  logic        exp_store_q [$];
  int          exp_id_q [$];

  int seed        = 51150;
  int cycle_cnt   = 0;
  int cycle_limit = TRACE_MAX * CYC_PER_OP;
  int outstanding = 0;
  int test_errs   = 0;

  lsu_top #(
    .LSU_DEPTH (DEPTH)
  ) u_lsu_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .op_valid_i      (op_valid_i),
    .op_i            (op_i),
    .op_ready_o      (op_ready_o),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_o       (bus_req_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .bus_rdata_i     (bus_rdata_i),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // Split when a word is off alignment or a halfword sits at offset 3
  function automatic int reqs_for(input lsu_pkg::lsu_opcode_e opc, input logic [1:0] off);
    int n;
    n = 1;
    if ((opc == lsu_pkg::LW || opc == lsu_pkg::SW) && off != 2'd0)
      n = 2;
    if ((opc == lsu_pkg::LH || opc == lsu_pkg::LHU || opc == lsu_pkg::SH) && off == 2'd3)
      n = 2;
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////////////////////////

  // Applies enables, snapshots the word and schedules a reply 1 to 3 cycles out
  task automatic accept_req(input lsu_pkg::bus_req_t req);
    logic [31:0] word;
    int          base;
    int          k;
    base = 4 * int'(req.addr[5:2]);
    for (k = 0; k < 4; k++)
    begin
      if (req.we && req.be[k])
        mem[base + k] = req.wdata[8*k +: 8];
      word[8*k +: 8] = mem[base + k];
    end
    rsp_data_q.push_back(word);
    rsp_due_q.push_back(cycle_cnt + int'($unsigned($random(seed)) % 3));
  endtask

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (rst_n)
    begin
      if (bus_req_valid_o && bus_req_ready_i)
      begin
        // Queue depth caps what may be in flight
        if (outstanding >= DEPTH)
        begin
          $display("error at %0t: request accepted with %0d transactions in flight",
                   $time, outstanding);
          test_errs++;
        end
        accept_req(bus_req_o);
        outstanding++;
      end
      if (bus_rsp_valid_i)
        outstanding--;
    end
  end

  // Random ready and replies driven once they are due
  always @(negedge clk)
  begin
    bus_req_ready_i = (($random(seed) & 3) != 0);
    if ((rsp_due_q.size() > 0) && (rsp_due_q[0] <= cycle_cnt))
    begin
      bus_rsp_valid_i = 1'b1;
      bus_rdata_i     = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end
    else
    begin
      bus_rsp_valid_i = 1'b0;
      bus_rdata_i     = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Issue and scoreboard
  ////////////////////////////////////////////////////////////

  // Holds one operation until accepted and counts its bus requests
  task automatic issue_op(input int idx);
    lsu_pkg::lsu_opcode_e opc;
    int                   base;
    int                   n_req;
    base  = idx * TRACE_COLS;
    opc   = lsu_pkg::lsu_opcode_e'(trace_mem[base+1][2:0]);
    n_req = 0;
    @(negedge clk);
    op_valid_i  = 1'b1;
    op_i.opcode = opc;
    op_i.addr   = trace_mem[base+2];
    op_i.wdata  = trace_mem[base+3];
    exp_rdata_q.push_back(trace_mem[base+4]);
    exp_store_q.push_back(opc inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW});
    exp_id_q.push_back(int'(trace_mem[base]));
    do
    begin
      @(posedge clk);
      if (bus_req_valid_o && bus_req_ready_i)
        n_req++;
    end
    while (!op_ready_o);
    if (n_req != reqs_for(opc, op_i.addr[1:0]))
    begin
      $display("mismatch at %0t: line %0d made %0d bus requests, expected %0d",
               $time, idx, n_req, reqs_for(opc, op_i.addr[1:0]));
      test_errs++;
    end
  endtask

  // Results must match the oldest issued operation
  always @(posedge clk)
  begin
    if (rst_n && result_valid_o)
    begin
      if (exp_rdata_q.size() == 0)
      begin
        $display("error at %0t: result appeared with no operation outstanding", $time);
        test_errs++;
      end
      else
      begin
        if (result_o.rdata !== exp_rdata_q[0] || result_o.is_store !== exp_store_q[0])
        begin
          $display("mismatch at %0t: test %0d got %h store %b, expected %h store %b",
                   $time, exp_id_q[0], result_o.rdata, result_o.is_store,
                   exp_rdata_q[0], exp_store_q[0]);
          test_errs++;
        end
        void'(exp_rdata_q.pop_front());
        void'(exp_store_q.pop_front());
        void'(exp_id_q.pop_front());
      end
    end
  end

  initial
  begin
    int i;
    int n_ops;
    int idx;
    int first;
    int cur_id;
    int n_pass;
    int n_fail;
    clk             = 1'b0;
    rst_n           = 1'b0;
    op_valid_i      = 1'b0;
    op_i            = '0;
    bus_req_ready_i = 1'b0;
    bus_rsp_valid_i = 1'b0;
    bus_rdata_i     = '0;
    n_pass          = 0;
    n_fail          = 0;
    for (i = 0; i < 64; i++)
      mem[i] = '0;
    for (i = 0; i < TRACE_MAX * TRACE_COLS; i++)
      trace_mem[i] = '0;
    $readmemh("tests/lsu_trace.txt", trace_mem);
    // Test id zero ends the trace
    n_ops = 0;
    while (n_ops < TRACE_MAX && trace_mem[n_ops*TRACE_COLS] != 0)
      n_ops++;
    cycle_limit = n_ops * CYC_PER_OP;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    idx   = 0;
    while (idx < n_ops)
    begin
      cur_id    = int'(trace_mem[idx*TRACE_COLS]);
      first     = idx;
      test_errs = 0;
      while (idx < n_ops && int'(trace_mem[idx*TRACE_COLS]) == cur_id)
      begin
        issue_op(idx);
        idx++;
      end
      @(negedge clk);
      op_valid_i = 1'b0;
      // Drain every result of this test
      while (exp_rdata_q.size() != 0)
        @(negedge clk);
      if (test_errs == 0)
      begin
        n_pass++;
        $display("test %0d: %0d operations, ok", cur_id, idx - first);
      end
      else
      begin
        n_fail++;
        $display("test %0d: %0d operations, %0d errors", cur_id, idx - first, test_errs);
      end
    end
    $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && n_pass > 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // Cycle budget scales with the trace length
  initial
  begin
    @(negedge clk);
    while (cycle_cnt < cycle_limit)
      @(negedge clk);
    $display("timeout after %0d cycles, %0d results never arrived",
             cycle_cnt, exp_rdata_q.size());
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== tests/lsu_trace.txt ====
// Columns, all hex: test id, opcode (LB 0 LH 1 LW 2 LBU 3 LHU 4 SB 5 SH 6 SW 7),
// address, store data, expected result (zero for stores)
1 7 00000000 11223344 00000000
1 6 00000006 0000a5b6 00000000
1 5 00000009 000000c7 00000000
1 5 0000000a ffffff5a 00000000
1 2 00000000 00000000 11223344
1 2 00000004 00000000 a5b60000
1 4 00000006 00000000 0000a5b6
1 2 00000008 00000000 005ac700
2 0 00000009 00000000 ffffffc7
2 3 00000009 00000000 000000c7
2 1 00000006 00000000 ffffa5b6
2 4 00000006 00000000 0000a5b6
2 0 0000000a 00000000 0000005a
2 1 00000008 00000000 ffffc700
3 7 00000011 8899aabb 00000000
3 2 00000011 00000000 8899aabb
3 7 0000001a deadbeef 00000000
3 2 0000001a 00000000 deadbeef
3 7 00000023 01234567 00000000
3 2 00000023 00000000 01234567
3 6 0000002b 0000f00d 00000000
3 1 0000002b 00000000 fffff00d
3 4 0000002b 00000000 0000f00d
3 2 00000012 00000000 008899aa
